// File: design/bridge_pkg.sv
package bridge_pkg;

	// line geometry
	localparam int beats_per_line = 4;
	localparam int line_bits      = 128;

	// backing memory of the subsystem
	localparam int mem_words      = 256;
	localparam int mem_addr_bits  = 8;   // word index width

	// AXI IDs steer returned beats to their cache
	localparam logic id_icache = 1'b0;
	localparam logic id_dcache = 1'b1;

	typedef enum logic {
		req_word = 1'b0,  // one 32-bit word
		req_line = 1'b1   // four-beat incrementing burst
	} req_kind_e;

	// cache read request
	typedef struct packed {
		req_kind_e   kind;
		logic [31:0] addr;
	} rd_req_s;

	// read address beat
	typedef struct packed {
		logic        id;
		logic [31:0] addr;
		logic [7:0]  len;  // 0 or 3
	} ar_beat_s;

	// read data beat
	typedef struct packed {
		logic        id;
		logic [31:0] data;
		logic        last;
	} r_beat_s;

	// a cache line, whole or as beats; words[0] is the lowest address
	typedef union packed {
		logic [line_bits-1:0]                            flat;
		logic [beats_per_line-1:0][line_bits/beats_per_line-1:0] words;
	} line_u;

	// data cache write request, single word data sits in words[0]
	typedef struct packed {
		req_kind_e   kind;
		logic [31:0] addr;
		logic [3:0]  wstrb;
		line_u       line;
	} wr_req_s;

	// write address beat
	typedef struct packed {
		logic [31:0] addr;
		logic [7:0]  len;
	} aw_beat_s;

	// write data beat
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
	} w_beat_s;

endpackage

// File: design/rd_arbiter.sv
`timescale 1ns/1ps

module rd_arbiter (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 icache_rd_req,
	input  bridge_pkg::rd_req_s  icache_req,
	input  logic                 dcache_rd_req,
	input  bridge_pkg::rd_req_s  dcache_req,
	output logic                 icache_rd_rdy,
	output logic                 dcache_rd_rdy,
	input  logic                 rd_busy,
	input  logic                 wr_pending,
	input  logic [31:0]          wr_line_addr,
	output bridge_pkg::ar_beat_s ar,
	output logic                 arvalid,
	input  logic                 arready
);

	logic                free;
	logic                d_hazard;
	logic                i_hazard;
	logic                d_grant;
	logic                i_grant;
	bridge_pkg::rd_req_s win;

	// channel free once the AR beat has gone and the burst is fully returned
	assign free = ~rd_busy & ~arvalid;

	// same line as a write still waiting for B
	assign d_hazard = wr_pending & (dcache_req.addr[31:4] == wr_line_addr[31:4]);
	assign i_hazard = wr_pending & (icache_req.addr[31:4] == wr_line_addr[31:4]);

	assign dcache_rd_rdy = free & ~d_hazard;
	// icache only loses to a dcache request that can actually go
	assign icache_rd_rdy = free & ~i_hazard & ~(dcache_rd_req & ~d_hazard);

	assign d_grant = dcache_rd_req & dcache_rd_rdy;
	assign i_grant = icache_rd_req & icache_rd_rdy;

	assign win = d_grant ? dcache_req : icache_req;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			arvalid <= 1'b0;
		end else if (d_grant | i_grant) begin
			arvalid <= 1'b1;
		end else if (arvalid & arready) begin
			arvalid <= 1'b0;
		end
	end

	// AR payload, held until the handshake
	always_ff @(posedge aclk) begin
		if (d_grant | i_grant) begin
			ar.id <= d_grant ? bridge_pkg::id_dcache : bridge_pkg::id_icache;
			if (win.kind == bridge_pkg::req_line) begin
				ar.addr <= {win.addr[31:4], 4'h0};  // line aligned
				ar.len  <= 8'(bridge_pkg::beats_per_line - 1);
			end else begin
				ar.addr <= win.addr;
				ar.len  <= 8'd0;
			end
		end
	end

endmodule

// File: design/rd_engine.sv
`timescale 1ns/1ps

module rd_engine (
	input  logic                aclk,
	input  logic                aresetn,
	input  bridge_pkg::r_beat_s r,
	input  logic                rvalid,
	output logic                rready,
	input  logic                arvalid,
	input  logic                arready,
	output logic                rd_busy,
	output logic                icache_ret_valid,
	output logic                icache_ret_last,
	output logic                dcache_ret_valid,
	output logic                dcache_ret_last,
	output logic [31:0]         ret_data
);

	logic        expect_r;    // burst outstanding on R
	logic        beat_valid;
	logic        beat_last;
	logic        beat_id;
	logic [31:0] beat_data;
	logic        r_fire;

	assign r_fire = rvalid & rready;
	assign rready = expect_r;

	// stays up through the cycle that returns the final word
	assign rd_busy = expect_r | (beat_valid & beat_last);

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			expect_r <= 1'b0;
		end else if (arvalid & arready) begin
			expect_r <= 1'b1;
		end else if (r_fire & r.last) begin
			expect_r <= 1'b0;
		end
	end

	// one-cycle buffer between R and the cache ports
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			beat_valid <= 1'b0;
			beat_last  <= 1'b0;
			beat_id    <= bridge_pkg::id_icache;
		end else begin
			beat_valid <= r_fire;
			beat_last  <= r_fire & r.last;
			if (r_fire) begin
				beat_id <= r.id;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (r_fire) begin
			beat_data <= r.data;
		end
	end

	assign ret_data = beat_data;

	assign icache_ret_valid = beat_valid & (beat_id == bridge_pkg::id_icache);
	assign icache_ret_last  = beat_valid & beat_last & (beat_id == bridge_pkg::id_icache);
	assign dcache_ret_valid = beat_valid & (beat_id == bridge_pkg::id_dcache);
	assign dcache_ret_last  = beat_valid & beat_last & (beat_id == bridge_pkg::id_dcache);

endmodule

// File: design/wr_engine.sv
`timescale 1ns/1ps

module wr_engine (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 dcache_wr_req,
	input  bridge_pkg::wr_req_s  dcache_wr,
	output logic                 dcache_wr_rdy,
	output logic                 wr_pending,
	output logic [31:0]          wr_line_addr,
	output bridge_pkg::aw_beat_s aw,
	output logic                 awvalid,
	input  logic                 awready,
	output bridge_pkg::w_beat_s  w,
	output logic                 wvalid,
	input  logic                 wready,
	input  logic                 bvalid,
	output logic                 bready
);

	logic                                        busy;
	logic                                        accept;
	logic                                        w_fire;
	logic                                        w_last;
	logic                                        is_line;
	logic [$clog2(bridge_pkg::beats_per_line)-1:0] beat_cnt;
	bridge_pkg::req_kind_e                       kind_q;
	logic [31:0]                                 addr_q;
	logic [3:0]                                  wstrb_q;
	bridge_pkg::line_u                           line_q;

	assign accept = dcache_wr_req & dcache_wr_rdy;
	assign w_fire = wvalid & wready;
	assign is_line = (kind_q == bridge_pkg::req_line);

	assign dcache_wr_rdy = ~busy;

	// covers the accept cycle too, so a read in that same cycle is held off
	assign wr_pending   = busy | dcache_wr_req;
	assign wr_line_addr = busy ? addr_q : dcache_wr.addr;

	// wait for B once both AW and all W beats are out
	assign bready = busy & ~awvalid & ~wvalid;

	assign w_last = ~is_line | (beat_cnt == ($bits(beat_cnt))'(bridge_pkg::beats_per_line - 1));

	always_comb begin
		aw.addr = is_line ? {addr_q[31:4], 4'h0} : addr_q;
		aw.len  = is_line ? 8'(bridge_pkg::beats_per_line - 1) : 8'd0;
		w.data  = line_q.words[0];  // current beat always at the bottom
		w.strb  = is_line ? 4'hf : wstrb_q;
		w.last  = w_last;
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy     <= 1'b0;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			beat_cnt <= '0;
		end else if (accept) begin
			busy     <= 1'b1;
			awvalid  <= 1'b1;
			wvalid   <= 1'b1;
			beat_cnt <= '0;
		end else begin
			if (awvalid & awready) begin
				awvalid <= 1'b0;
			end
			// AW and W finish in any order
			if (w_fire) begin
				if (w_last) begin
					wvalid <= 1'b0;
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end
			if (bvalid & bready) begin
				busy <= 1'b0;  // one B closes the burst
			end
		end
	end

	// request copy; the line shifts down one word per W beat
	always_ff @(posedge aclk) begin
		if (accept) begin
			kind_q  <= dcache_wr.kind;
			addr_q  <= dcache_wr.addr;
			wstrb_q <= dcache_wr.wstrb;
			line_q  <= dcache_wr.line;
		end else if (w_fire) begin
			line_q.flat <= line_q.flat >> $bits(line_q.words[0]);
		end
	end

endmodule

// File: design/axi_mem.sv
`timescale 1ns/1ps

module axi_mem (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  bridge_pkg::ar_beat_s ar,
	input  logic                 arvalid,
	output logic                 arready,
	output bridge_pkg::r_beat_s  r,
	output logic                 rvalid,
	input  logic                 rready,
	input  bridge_pkg::aw_beat_s aw,
	input  logic                 awvalid,
	output logic                 awready,
	input  bridge_pkg::w_beat_s  w,
	input  logic                 wvalid,
	output logic                 wready,
	output logic                 bvalid,
	input  logic                 bready
);

	// stored as lines, indexed by word address
	bridge_pkg::line_u mem_q [bridge_pkg::mem_words / bridge_pkg::beats_per_line];

	logic [bridge_pkg::mem_addr_bits-1:0] rd_idx;
	logic [bridge_pkg::mem_addr_bits-1:0] wr_idx;
	logic [7:0]                           rd_left;
	logic [7:0]                           wr_left;
	logic                                 rd_id;
	logic                                 wr_known;  // AW taken, W beats expected
	logic                                 w_fire;
	logic                                 w_end;

	assign arready = ~rvalid;
	assign awready = ~wr_known & ~bvalid;
	assign wready  = wr_known;

	assign w_fire = wvalid & wready;
	assign w_end  = w.last | (wr_left == 8'd0);  // stop at len either way

	// R beat straight from the array, stable while rready is low
	always_comb begin
		r.id   = rd_id;
		r.data = mem_q[rd_idx / bridge_pkg::beats_per_line].words[rd_idx % bridge_pkg::beats_per_line];
		r.last = (rd_left == 8'd0);
	end

	// read burst
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rvalid  <= 1'b0;
			rd_idx  <= '0;
			rd_left <= 8'd0;
			rd_id   <= 1'b0;
		end else if (arvalid & arready) begin
			rvalid  <= 1'b1;  // first beat a cycle after the address
			rd_idx  <= ar.addr[bridge_pkg::mem_addr_bits+1:2];
			rd_left <= ar.len;
			rd_id   <= ar.id;
		end else if (rvalid & rready) begin
			if (r.last) begin
				rvalid <= 1'b0;
			end else begin
				rd_idx  <= rd_idx + 1'b1;
				rd_left <= rd_left - 1'b1;
			end
		end
	end

	// write burst and array update
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_known <= 1'b0;
			bvalid   <= 1'b0;
			wr_idx   <= '0;
			wr_left  <= 8'd0;
			for (int i = 0; i < bridge_pkg::mem_words / bridge_pkg::beats_per_line; i++) begin
				mem_q[i].flat <= '0;
			end
		end else begin
			if (awvalid & awready) begin
				wr_known <= 1'b1;
				wr_idx   <= aw.addr[bridge_pkg::mem_addr_bits+1:2];
				wr_left  <= aw.len;
			end
			if (w_fire) begin
				// byte lanes under strb
				for (int b = 0; b < 4; b++) begin
					if (w.strb[b]) begin
						mem_q[wr_idx / bridge_pkg::beats_per_line]
							.words[wr_idx % bridge_pkg::beats_per_line][b*8 +: 8] <= w.data[b*8 +: 8];
					end
				end
				wr_idx  <= wr_idx + 1'b1;
				wr_left <= wr_left - 1'b1;
				if (w_end) begin
					wr_known <= 1'b0;
					bvalid   <= 1'b1;  // B the cycle after the last beat
				end
			end
			if (bvalid & bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

// File: design/cache_axi_top.sv
`timescale 1ns/1ps

module cache_axi_top (
	input  logic                aclk,
	input  logic                aresetn,
	// icache read port
	input  logic                icache_rd_req,
	input  bridge_pkg::rd_req_s icache_req,
	output logic                icache_rd_rdy,
	output logic                icache_ret_valid,
	output logic                icache_ret_last,
	// dcache read port
	input  logic                dcache_rd_req,
	input  bridge_pkg::rd_req_s dcache_req,
	output logic                dcache_rd_rdy,
	output logic                dcache_ret_valid,
	output logic                dcache_ret_last,
	output logic [31:0]         ret_data,  // shared by both read ports
	// dcache write port
	input  logic                dcache_wr_req,
	input  bridge_pkg::wr_req_s dcache_wr,
	output logic                dcache_wr_rdy
);

	bridge_pkg::ar_beat_s ar;
	bridge_pkg::r_beat_s  r;
	bridge_pkg::aw_beat_s aw;
	bridge_pkg::w_beat_s  w;
	logic                 arvalid;
	logic                 arready;
	logic                 rvalid;
	logic                 rready;
	logic                 awvalid;
	logic                 awready;
	logic                 wvalid;
	logic                 wready;
	logic                 bvalid;
	logic                 bready;
	logic                 rd_busy;
	logic                 wr_pending;
	logic [31:0]          wr_line_addr;

	rd_arbiter u_rd_arbiter (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.icache_rd_req (icache_rd_req),
		.icache_req    (icache_req),
		.dcache_rd_req (dcache_rd_req),
		.dcache_req    (dcache_req),
		.icache_rd_rdy (icache_rd_rdy),
		.dcache_rd_rdy (dcache_rd_rdy),
		.rd_busy       (rd_busy),
		.wr_pending    (wr_pending),
		.wr_line_addr  (wr_line_addr),
		.ar            (ar),
		.arvalid       (arvalid),
		.arready       (arready)
	);

	rd_engine u_rd_engine (
		.aclk             (aclk),
		.aresetn          (aresetn),
		.r                (r),
		.rvalid           (rvalid),
		.rready           (rready),
		.arvalid          (arvalid),
		.arready          (arready),
		.rd_busy          (rd_busy),
		.icache_ret_valid (icache_ret_valid),
		.icache_ret_last  (icache_ret_last),
		.dcache_ret_valid (dcache_ret_valid),
		.dcache_ret_last  (dcache_ret_last),
		.ret_data         (ret_data)
	);

	wr_engine u_wr_engine (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.dcache_wr_req (dcache_wr_req),
		.dcache_wr     (dcache_wr),
		.dcache_wr_rdy (dcache_wr_rdy),
		.wr_pending    (wr_pending),
		.wr_line_addr  (wr_line_addr),
		.aw            (aw),
		.awvalid       (awvalid),
		.awready       (awready),
		.w             (w),
		.wvalid        (wvalid),
		.wready        (wready),
		.bvalid        (bvalid),
		.bready        (bready)
	);

	axi_mem u_axi_mem (
		.aclk    (aclk),
		.aresetn (aresetn),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

// File: tb/bridge_checker.sv
`timescale 1ns/1ps

module bridge_checker (
	input logic        aclk,
	input logic        aresetn,
	input logic        icache_rd_req,
	input logic        icache_rd_rdy,
	input logic        dcache_rd_req,
	input logic        icache_ret_valid,
	input logic        icache_ret_last,
	input logic        dcache_ret_valid,
	input logic        dcache_ret_last,
	input logic [31:0] ret_data,
	input logic        dcache_wr_req,
	input logic        dcache_wr_rdy
);

	// one expected return word
	typedef struct packed {
		logic [15:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic        last;
	} exp_s;

	exp_s       i_q[$];
	exp_s       d_q[$];
	int         w_q[$];  // write ops not yet accepted
	int         w_op;
	logic       w_busy = 1'b0;
	logic [1:0] bad = 2'b00;  // mismatch seen in current op, per port
	int         errors = 0;
	int         ops_done = 0;
	int         ops_failed = 0;

	task automatic expect_word(input logic dport, input int op, input logic [31:0] addr,
		input logic [31:0] data, input logic last);
		exp_s e;
		e.op   = 16'(op);
		e.addr = addr;
		e.data = data;
		e.last = last;
		if (dport) begin
			d_q.push_back(e);
		end else begin
			i_q.push_back(e);
		end
	endtask

	task automatic expect_write(input int op);
		w_q.push_back(op);
	endtask

	function automatic int reads_pending();
		return i_q.size() + d_q.size();
	endfunction

	function automatic int pending();
		return i_q.size() + d_q.size() + w_q.size() + int'(w_busy);
	endfunction

	task automatic check_return(input logic dport, input logic last_seen);
		exp_s  e;
		string name;
		name = dport ? "dcache" : "icache";
		if ((dport ? d_q.size() : i_q.size()) == 0) begin
			errors++;
			$display("unexpected return on the %s port at %0d ns, data %08h", name, $time, ret_data);
		end else begin
			e = dport ? d_q.pop_front() : i_q.pop_front();
			if (ret_data !== e.data) begin
				errors++;
				bad[dport] = 1'b1;
				$display("[ERROR] %0d ns: op %0d %s read at %08h returned %08h, expected %08h",
					$time, e.op, name, e.addr, ret_data, e.data);
			end
			if (e.last && !last_seen) begin
				errors++;
				bad[dport] = 1'b1;
				$display("op %0d: final word on the %s port came without ret_last", e.op, name);
			end else if (!e.last && last_seen) begin
				errors++;
				bad[dport] = 1'b1;
				$display("op %0d: ret_last on the %s port before the final word", e.op, name);
			end
			if (e.last) begin
				ops_done++;
				if (bad[dport]) begin
					ops_failed++;
				end
				$display("op %0d %s read %08h: %s", e.op, name, e.addr, bad[dport] ? "FAILED" : "ok");
				bad[dport] = 1'b0;
			end
		end
	endtask

	task automatic report(input int n_ops);
		$display("%0d of %0d ops done, %0d failed, %0d errors", ops_done, n_ops, ops_failed, errors);
	endtask

	always @(posedge aclk) begin
		if (aresetn) begin
			if (icache_ret_valid) begin
				check_return(1'b0, icache_ret_last);
			end
			if (dcache_ret_valid) begin
				check_return(1'b1, dcache_ret_last);
			end
			// fixed priority, dcache first
			if (icache_rd_req && icache_rd_rdy && dcache_rd_req) begin
				errors++;
				$display("icache read granted at %0d ns while a dcache read was waiting", $time);
			end
			if (w_busy && dcache_wr_rdy) begin  // port idle again, B came back
				w_busy = 1'b0;
				ops_done++;
				$display("op %0d write: done", w_op);
			end
			if (dcache_wr_req && dcache_wr_rdy) begin
				if (w_q.size() == 0) begin
					errors++;
					$display("write accepted at %0d ns with no write issued", $time);
				end else begin
					w_op   = w_q.pop_front();
					w_busy = 1'b1;
				end
			end
		end
	end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

	localparam int cols          = 9;   // words per golden line
	localparam int max_ops       = 64;
	localparam int cycles_per_op = 60;
	localparam int reset_cycles  = 4;

	logic                aclk = 1'b0;
	logic                aresetn;
	logic                icache_rd_req;
	bridge_pkg::rd_req_s icache_req;
	logic                icache_rd_rdy;
	logic                icache_ret_valid;
	logic                icache_ret_last;
	logic                dcache_rd_req;
	bridge_pkg::rd_req_s dcache_req;
	logic                dcache_rd_rdy;
	logic                dcache_ret_valid;
	logic                dcache_ret_last;
	logic [31:0]         ret_data;
	logic                dcache_wr_req;
	bridge_pkg::wr_req_s dcache_wr;
	logic                dcache_wr_rdy;

	logic [31:0] gold [cols*max_ops];
	int          n_ops;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	always #2 aclk = ~aclk;

	cache_axi_top uut (
		.aclk             (aclk),
		.aresetn          (aresetn),
		.icache_rd_req    (icache_rd_req),
		.icache_req       (icache_req),
		.icache_rd_rdy    (icache_rd_rdy),
		.icache_ret_valid (icache_ret_valid),
		.icache_ret_last  (icache_ret_last),
		.dcache_rd_req    (dcache_rd_req),
		.dcache_req       (dcache_req),
		.dcache_rd_rdy    (dcache_rd_rdy),
		.dcache_ret_valid (dcache_ret_valid),
		.dcache_ret_last  (dcache_ret_last),
		.ret_data         (ret_data),
		.dcache_wr_req    (dcache_wr_req),
		.dcache_wr        (dcache_wr),
		.dcache_wr_rdy    (dcache_wr_rdy)
	);

	bridge_checker chk (
		.aclk             (aclk),
		.aresetn          (aresetn),
		.icache_rd_req    (icache_rd_req),
		.icache_rd_rdy    (icache_rd_rdy),
		.dcache_rd_req    (dcache_rd_req),
		.icache_ret_valid (icache_ret_valid),
		.icache_ret_last  (icache_ret_last),
		.dcache_ret_valid (dcache_ret_valid),
		.dcache_ret_last  (dcache_ret_last),
		.ret_data         (ret_data),
		.dcache_wr_req    (dcache_wr_req),
		.dcache_wr_rdy    (dcache_wr_rdy)
	);

	always @(posedge aclk) begin
		cycle_cnt++;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic load_golden();
		for (int k = 0; k < cols*max_ops; k++) begin
			gold[k] = 32'hdead_0000 | 32'(k);  // never a valid op code
		end
		$readmemh("tb/golden_bridge.txt", gold);
		n_ops = 0;
		while (n_ops < max_ops && gold[n_ops*cols] <= 2) begin
			n_ops++;
		end
	endtask

	// a write and the read of its own line right behind it start in the same cycle
	function automatic logic read_joins_write(input int k);
		return gold[k*cols] == 2 && gold[(k+1)*cols] != 2
			&& gold[k*cols+2][31:4] == gold[(k+1)*cols+2][31:4];
	endfunction

	// expected words for one read line of the file
	task automatic queue_read(input logic dport, input int k);
		int base;
		int n;
		base = k*cols;
		n = gold[base+1][0] ? bridge_pkg::beats_per_line : 1;
		for (int j = 0; j < n; j++) begin
			chk.expect_word(dport, k, gold[base+2], gold[base+4+j], j == n-1);
		end
	endtask

	// drive ops first..last together and hold each until its rdy
	task automatic run_group(input int first, input int last);
		int                  base;
		bridge_pkg::rd_req_s rq;
		bridge_pkg::wr_req_s wq;
		logic                i_act;
		logic                d_act;
		logic                w_act;
		i_act = 1'b0;
		d_act = 1'b0;
		w_act = 1'b0;
		@(posedge aclk);
		for (int k = first; k <= last; k++) begin
			base    = k*cols;
			rq.kind = bridge_pkg::req_kind_e'(gold[base+1][0]);
			rq.addr = gold[base+2];
			if (gold[base] == 0) begin
				queue_read(1'b0, k);
				icache_req    <= rq;
				icache_rd_req <= 1'b1;
				i_act = 1'b1;
			end else if (gold[base] == 1) begin
				queue_read(1'b1, k);
				dcache_req    <= rq;
				dcache_rd_req <= 1'b1;
				d_act = 1'b1;
			end else begin
				wq.kind  = rq.kind;
				wq.addr  = rq.addr;
				wq.wstrb = gold[base+3][3:0];
				for (int j = 0; j < bridge_pkg::beats_per_line; j++) begin
					wq.line.words[j] = gold[base+4+j];
				end
				chk.expect_write(k);
				dcache_wr     <= wq;
				dcache_wr_req <= 1'b1;
				w_act = 1'b1;
			end
		end
		while (i_act || d_act || w_act) begin
			@(posedge aclk);
			if (i_act && icache_rd_rdy) begin
				icache_rd_req <= 1'b0;
				i_act = 1'b0;
			end
			if (d_act && dcache_rd_rdy) begin
				dcache_rd_req <= 1'b0;
				d_act = 1'b0;
			end
			if (w_act && dcache_wr_rdy) begin
				dcache_wr_req <= 1'b0;
				w_act = 1'b0;
			end
		end
		// reads drain before the next group while writes may still be in flight
		while (chk.reads_pending() != 0) begin
			@(posedge aclk);
		end
	endtask

	initial begin
		int first;
		int i;
		aresetn       = 1'b0;
		icache_rd_req = 1'b0;
		icache_req    = '0;
		dcache_rd_req = 1'b0;
		dcache_req    = '0;
		dcache_wr_req = 1'b0;
		dcache_wr     = '0;
		load_golden();
		cycle_limit = reset_cycles + cycles_per_op*n_ops;
		repeat (reset_cycles) @(posedge aclk);
		aresetn <= 1'b1;
		if (n_ops == 0) begin
			$display("no operations could be read from tb/golden_bridge.txt");
		end else begin
			i = 0;
			while (i < n_ops) begin
				first = i;
				while (i+1 < n_ops && (gold[i*cols+8] != 0 || read_joins_write(i))) begin
					i++;  // joined lines go out together
				end
				run_group(first, i);
				i++;
			end
			while (chk.pending() != 0) begin
				@(posedge aclk);
			end
			repeat (4) @(posedge aclk);  // catch stray returns
		end
		chk.report(n_ops);
		if (chk.errors == 0 && n_ops > 0 && chk.ops_done == n_ops) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb/golden_bridge.txt
// op: 0 i-read, 1 d-read, 2 write | kind: 0 word, 1 line | byte address | wstrb
// d0..d3: write data, or expected read words | join: 1 issues this line together with the next
2 1 00000040 f 11111111 22222222 33333333 44444444 0
1 1 00000040 0 11111111 22222222 33333333 44444444 0
2 0 00000044 5 aabbccdd 00000000 00000000 00000000 0
1 0 00000044 0 22bb22dd 00000000 00000000 00000000 0
0 0 00000048 0 33333333 00000000 00000000 00000000 0
2 1 00000080 f 80000000 80000001 80000002 80000003 0
1 1 00000080 0 80000000 80000001 80000002 80000003 0
0 1 00000040 0 11111111 22bb22dd 33333333 44444444 1
1 1 00000080 0 80000000 80000001 80000002 80000003 0
0 0 00000084 0 80000001 00000000 00000000 00000000 1
1 0 0000004c 0 44444444 00000000 00000000 00000000 0
0 1 00000200 0 00000000 00000000 00000000 00000000 0
2 1 00000100 f a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 0
1 1 00000040 0 11111111 22bb22dd 33333333 44444444 0
0 1 00000100 0 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 0
2 0 000003fc 8 5a000000 00000000 00000000 00000000 0
1 0 000003fc 0 5a000000 00000000 00000000 00000000 0
1 1 000003f0 0 00000000 00000000 00000000 5a000000 0
2 1 00000100 0 b0b0b0b0 b1b1b1b1 b2b2b2b2 b3b3b3b3 0
0 1 00000100 0 b0b0b0b0 b1b1b1b1 b2b2b2b2 b3b3b3b3 0
2 0 00000000 3 1234beef 00000000 00000000 00000000 0
1 0 00000000 0 0000beef 00000000 00000000 00000000 0

// File: filelist.f
design/bridge_pkg.sv
design/rd_arbiter.sv
design/rd_engine.sv
design/wr_engine.sv
design/axi_mem.sv
design/cache_axi_top.sv
tb/bridge_checker.sv
tb/tb_top.sv
